// ==== design/synctimer_pkg.sv ====
// widths, fixed-point constants, filter gains, timer step, shared types and divider states
package synctimer_pkg;

    localparam int unsigned TIMER_WIDTH   = 64;
    localparam int unsigned CALC_WIDTH    = 32; // low part of the time used in arithmetic
    localparam int unsigned COUNTER_WIDTH = 32;
    localparam int unsigned ERROR_WIDTH   = 32;
    localparam int unsigned ERROR_Q       = 8;  // fraction bits of the errors
    localparam int unsigned ADJUST_Q      = 8;  // fraction bits of the nudge period
    localparam int unsigned ADJUST_WIDTH  = COUNTER_WIDTH + ERROR_Q;
    localparam int unsigned QUOT_WIDTH    = ADJUST_WIDTH + ADJUST_Q;
    localparam int unsigned DIV_CNT_WIDTH = $clog2(QUOT_WIDTH);

    // gains as right shifts, 1/2^n
    localparam int unsigned PHASE_LPF_GAIN  = 4;
    localparam int unsigned PERIOD_LPF_GAIN = 4;

    localparam int unsigned TIMER_STEP = 10; // time units per clock

    typedef logic [TIMER_WIDTH-1:0]                    timer_t;
    typedef logic [CALC_WIDTH-1:0]                     calc_t;
    typedef logic signed [ERROR_WIDTH-1:0]             phase_t;
    typedef logic signed [ERROR_WIDTH+ERROR_Q-1:0]     error_t;
    typedef logic [ERROR_WIDTH+ERROR_Q-1:0]            error_u_t;
    typedef logic [COUNTER_WIDTH+ADJUST_Q-1:0]         count_q_t;
    typedef logic [QUOT_WIDTH-1:0]                     adjust_t;

    // one cycle in nudge-period fixed point
    localparam adjust_t ADJ_STEP = adjust_t'(1) << ADJUST_Q;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_e;

    // integer time difference to error fixed point
    function automatic error_t to_error(input phase_t value);
        return error_t'(value) <<< ERROR_Q;
    endfunction

endpackage

// ==== design/synctimer_timer.sv ====
// disciplined local timer with override load and single-unit nudges
`timescale 1ns/1ps

module synctimer_timer (
    input  logic                  clk,
    input  logic                  reset,
    input  synctimer_pkg::timer_t correct_time,
    input  logic                  correct_valid,
    input  logic                  correct_override,
    input  logic                  adjust_valid,
    input  logic                  adjust_sign,
    output synctimer_pkg::timer_t current_time
);

    import synctimer_pkg::*;

    timer_t step;
    logic   load;

    assign load = correct_valid && correct_override;

    // nominal step, one more or one less on a nudge
    always_comb begin
        step = timer_t'(TIMER_STEP);
        if (adjust_valid) begin
            if (adjust_sign) begin
                step = timer_t'(TIMER_STEP - 1); // slow down
            end else begin
                step = timer_t'(TIMER_STEP + 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            current_time <= '0;
        end else if (load) begin
            current_time <= correct_time;
        end else begin
            current_time <= current_time + step;
        end
    end

endmodule

// ==== design/synctimer_error_calc.sv ====
// phase and period error measurement, pipeline stages 0 and 1
`timescale 1ns/1ps

module synctimer_error_calc (
    input  logic                  clk,
    input  logic                  reset,
    input  synctimer_pkg::timer_t local_time,
    input  synctimer_pkg::timer_t correct_time,
    input  logic                  correct_valid,
    input  logic                  correct_override,
    output synctimer_pkg::error_t phase_error,
    output synctimer_pkg::error_t period_error,
    output logic                  err_valid,
    output logic                  first_clear
);

    import synctimer_pkg::*;

    calc_t  local_calc;
    calc_t  correct_calc;
    logic   override;

    calc_t  st0_prev_local;
    calc_t  st0_prev_correct;
    calc_t  st0_local_period;
    calc_t  st0_correct_period;
    phase_t st0_phase;
    logic   st0_first;
    logic   st0_valid;
    logic   st0_override;

    assign local_calc   = calc_t'(local_time);
    assign correct_calc = calc_t'(correct_time);
    assign override     = correct_valid && correct_override;

    // stage 0
    always_ff @(posedge clk) begin
        if (reset) begin
            st0_first    <= 1'b1;
            st0_valid    <= 1'b0;
            st0_override <= 1'b0;
        end else begin
            st0_valid    <= correct_valid && !(st0_first || correct_override);
            st0_override <= override;
            if (correct_valid) begin
                st0_first <= correct_override; // periods are meaningless right after a load
            end
        end
    end

    always_ff @(posedge clk) begin
        if (correct_valid) begin
            st0_prev_local     <= local_calc;
            st0_prev_correct   <= correct_calc;
            st0_local_period   <= local_calc - st0_prev_local;
            st0_correct_period <= correct_calc - st0_prev_correct;
            st0_phase          <= phase_t'(correct_calc - local_calc);
        end
    end

    // stage 1
    always_ff @(posedge clk) begin
        if (reset) begin
            err_valid   <= 1'b0;
            first_clear <= 1'b0;
        end else begin
            err_valid   <= st0_valid;
            first_clear <= st0_override;
        end
    end

    always_ff @(posedge clk) begin
        if (st0_valid) begin
            phase_error  <= to_error(st0_phase);
            period_error <= to_error(phase_t'(st0_correct_period - st0_local_period));
        end
    end

endmodule

// ==== design/synctimer_loop_filter.sv ====
// phase low-pass with clamp, period integrator, sum and sign/magnitude split
`timescale 1ns/1ps

module synctimer_loop_filter (
    input  logic                    clk,
    input  logic                    reset,
    input  synctimer_pkg::phase_t   phase_min,
    input  synctimer_pkg::phase_t   phase_max,
    input  synctimer_pkg::error_t   phase_error,
    input  synctimer_pkg::error_t   period_error,
    input  logic                    err_valid,
    input  logic                    first_clear,
    input  logic                    div_in_ready,
    output synctimer_pkg::count_q_t dividend,
    output synctimer_pkg::error_u_t divisor,
    output logic                    div_in_valid,
    output logic                    adj_sign,
    output logic                    adj_zero
);

    import synctimer_pkg::*;

    error_t phase_lo;
    error_t phase_hi;
    error_t phase_corr;
    error_t period_corr;
    error_t phase_clamped;

    error_t phase_adj;
    error_t period_adj;
    logic   st2_valid;
    error_t st3_sum;
    logic   st3_valid;

    logic [COUNTER_WIDTH-1:0] cycle_cnt;
    logic                     held_sign;
    logic                     held_zero;

    assign phase_lo = to_error(phase_min);
    assign phase_hi = to_error(phase_max);

    // local period already holds the last phase correction, take it back out
    assign phase_corr  = phase_error - period_error;
    assign period_corr = period_error + phase_adj;

    always_comb begin
        phase_clamped = phase_corr;
        if (phase_corr <= phase_lo) phase_clamped = phase_lo;
        if (phase_corr >= phase_hi) phase_clamped = phase_hi;
    end

    // stage 2 low-pass and integrator
    always_ff @(posedge clk) begin
        if (reset) begin
            phase_adj  <= '0;
            period_adj <= '0;
            st2_valid  <= 1'b0;
        end else begin
            st2_valid <= err_valid;
            if (first_clear) begin
                phase_adj  <= '0;
                period_adj <= '0;
            end else if (err_valid) begin
                phase_adj  <= phase_clamped >>> PHASE_LPF_GAIN;
                period_adj <= period_adj + (period_corr >>> PERIOD_LPF_GAIN);
            end
        end
    end

    // stage 3
    always_ff @(posedge clk) begin
        if (reset) begin
            st3_valid <= 1'b0;
        end else begin
            st3_valid <= st2_valid;
        end
    end

    always_ff @(posedge clk) begin
        st3_sum <= period_adj + phase_adj;
    end

    // stage 4, held until the divider takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_cnt    <= '0;
            div_in_valid <= 1'b0;
            adj_sign     <= 1'b0;
            adj_zero     <= 1'b1;
        end else begin
            cycle_cnt <= st3_valid ? COUNTER_WIDTH'(1) : cycle_cnt + 1'b1;
            if (div_in_valid && div_in_ready) begin
                div_in_valid <= 1'b0;
                adj_sign     <= held_sign; // goes with the quotient now in flight
                adj_zero     <= held_zero;
            end
            if (st3_valid) div_in_valid <= 1'b1;
            if (first_clear) adj_zero <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (st3_valid) begin
            held_sign <= st3_sum < 0;
            held_zero <= st3_sum == 0;
            divisor   <= error_u_t'((st3_sum < 0) ? -st3_sum : st3_sum);
            dividend  <= count_q_t'(cycle_cnt) << (ERROR_Q + ADJUST_Q);
        end
    end

endmodule

// ==== design/synctimer_divider.sv ====
// multicycle restoring unsigned divider, one quotient bit per cycle
`timescale 1ns/1ps

module synctimer_divider (
    input  logic                    clk,
    input  logic                    reset,
    input  synctimer_pkg::count_q_t dividend,
    input  synctimer_pkg::error_u_t divisor,
    input  logic                    in_valid,
    output logic                    in_ready,
    output synctimer_pkg::adjust_t  quotient,
    output logic                    out_valid
);

    import synctimer_pkg::*;

    div_state_e               state;
    adjust_t                  shift_q; // dividend bits leave at the top, quotient enters below
    error_u_t                 rem;
    error_u_t                 den;
    logic [DIV_CNT_WIDTH-1:0] cnt;
    logic [$bits(error_u_t):0] trial;
    logic                     take;

    assign trial     = {rem, shift_q[QUOT_WIDTH-1]};
    assign take      = trial >= {1'b0, den}; // zero divisor always takes, so all ones
    assign in_ready  = (state != DIV_BUSY);
    assign out_valid = (state == DIV_DONE);
    assign quotient  = shift_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DIV_IDLE;
        end else begin
            case (state)
                DIV_BUSY: begin
                    if (cnt == DIV_CNT_WIDTH'(QUOT_WIDTH - 1)) state <= DIV_DONE;
                end
                default: begin
                    state <= in_valid ? DIV_BUSY : DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            shift_q <= adjust_t'(dividend);
            rem     <= '0;
            den     <= divisor;
            cnt     <= '0;
        end else if (state == DIV_BUSY) begin
            shift_q <= {shift_q[QUOT_WIDTH-2:0], take};
            if (take) begin
                rem <= error_u_t'(trial - {1'b0, den});
            end else begin
                rem <= error_u_t'(trial);
            end
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== design/synctimer_adjust_gen.sv ====
// nudge period update and paced nudge pulse generation
`timescale 1ns/1ps

module synctimer_adjust_gen (
    input  logic                   clk,
    input  logic                   reset,
    input  synctimer_pkg::adjust_t quotient,
    input  logic                   quot_valid,
    input  logic                   adj_sign,
    input  logic                   adj_zero,
    output logic                   adjust_valid,
    output logic                   adjust_sign
);

    import synctimer_pkg::*;

    adjust_t pend_period;
    logic    pend_sign;
    logic    pend_zero;
    logic    pend_valid;

    adjust_t run_period;
    adjust_t acc;
    logic    run_sign;
    logic    run_zero;
    logic    hit;

    assign hit = acc >= run_period;

    // pending parameters, adopted at the next expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else if (quot_valid) begin
            pend_valid <= 1'b1;
        end else if (hit) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (quot_valid) begin
            pend_sign <= adj_sign;
            pend_zero <= adj_zero;
            // hit cycle itself adds no step, so one step comes off here
            if (adj_zero || quotient <= ADJ_STEP) begin
                pend_period <= '0;
            end else begin
                pend_period <= quotient - ADJ_STEP;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc          <= '0;
            run_period   <= '0;
            run_sign     <= 1'b0;
            run_zero     <= 1'b1;
            adjust_valid <= 1'b0;
            adjust_sign  <= 1'b0;
        end else begin
            adjust_valid <= hit && !run_zero;
            adjust_sign  <= run_sign;
            if (hit) begin
                if (pend_valid) begin
                    run_period <= pend_period;
                    run_sign   <= pend_sign;
                    run_zero   <= pend_zero;
                    acc        <= '0;
                end else begin
                    acc <= acc - run_period; // keep the fraction
                end
            end else begin
                acc <= acc + ADJ_STEP;
            end
        end
    end

endmodule

// ==== design/synctimer_top.sv ====
// time-sync subsystem top, chains timer, error, filter, divider and nudge stages
`timescale 1ns/1ps

module synctimer_top (
    input  logic                  clk,
    input  logic                  reset,
    input  synctimer_pkg::phase_t phase_min,
    input  synctimer_pkg::phase_t phase_max,
    input  synctimer_pkg::timer_t correct_time,
    input  logic                  correct_valid,
    input  logic                  correct_override,
    output synctimer_pkg::timer_t current_time,
    output logic                  adjust_valid,
    output logic                  adjust_sign
);

    import synctimer_pkg::*;

    error_t   phase_error;
    error_t   period_error;
    logic     err_valid;
    logic     first_clear;
    count_q_t dividend;
    error_u_t divisor;
    logic     div_in_valid;
    logic     div_in_ready;
    logic     adj_sign;
    logic     adj_zero;
    adjust_t  quotient;
    logic     quot_valid;

    synctimer_timer timer_i (
        .clk              (clk),
        .reset            (reset),
        .correct_time     (correct_time),
        .correct_valid    (correct_valid),
        .correct_override (correct_override),
        .adjust_valid     (adjust_valid),
        .adjust_sign      (adjust_sign),
        .current_time     (current_time)
    );

    synctimer_error_calc error_calc_i (
        .clk              (clk),
        .reset            (reset),
        .local_time       (current_time),
        .correct_time     (correct_time),
        .correct_valid    (correct_valid),
        .correct_override (correct_override),
        .phase_error      (phase_error),
        .period_error     (period_error),
        .err_valid        (err_valid),
        .first_clear      (first_clear)
    );

    synctimer_loop_filter loop_filter_i (
        .clk          (clk),
        .reset        (reset),
        .phase_min    (phase_min),
        .phase_max    (phase_max),
        .phase_error  (phase_error),
        .period_error (period_error),
        .err_valid    (err_valid),
        .first_clear  (first_clear),
        .div_in_ready (div_in_ready),
        .dividend     (dividend),
        .divisor      (divisor),
        .div_in_valid (div_in_valid),
        .adj_sign     (adj_sign),
        .adj_zero     (adj_zero)
    );

    synctimer_divider divider_i (
        .clk       (clk),
        .reset     (reset),
        .dividend  (dividend),
        .divisor   (divisor),
        .in_valid  (div_in_valid),
        .in_ready  (div_in_ready),
        .quotient  (quotient),
        .out_valid (quot_valid)
    );

    synctimer_adjust_gen adjust_gen_i (
        .clk          (clk),
        .reset        (reset),
        .quotient     (quotient),
        .quot_valid   (quot_valid),
        .adj_sign     (adj_sign),
        .adj_zero     (adj_zero),
        .adjust_valid (adjust_valid),
        .adjust_sign  (adjust_sign)
    );

endmodule

// ==== verif/synctimer_tb.sv ====
// testbench for the time-sync subsystem: clock, reset, random master model, checks and report
`timescale 1ns/1ps

module synctimer_tb;

    import synctimer_pkg::*;

    // test lengths in cycles, worst case spacing of 600 cycles per sample
    localparam int unsigned T1_CYCLES  = 50;
    localparam int unsigned T2_CYCLES  = 2 * 600 + 50;
    localparam int unsigned T4_CYCLES  = 10 * 600 + 50;
    localparam int unsigned T5_CYCLES  = 100 * 600 + 100;
    localparam int unsigned MAX_CYCLES = (T1_CYCLES + T2_CYCLES + T4_CYCLES + T5_CYCLES) * 6 / 5;
    localparam int          PHASE_LIMIT = 2000;

    logic   clk = 1'b0;
    logic   reset;
    phase_t phase_min;
    phase_t phase_max;
    timer_t correct_time;
    logic   correct_valid;
    logic   correct_override;
    timer_t current_time;
    logic   adjust_valid;
    logic   adjust_sign;

    logic [31:0] seed = 32'h92bb2e1e;
    int unsigned cycles = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    // master model and drift
    timer_t      master;
    logic        drift_on = 1'b0;
    logic        drift_fast;
    int unsigned drift_period;
    int unsigned drift_cnt;

    // per-cycle monitor state
    timer_t      prev_time;
    logic        prev_adj;
    logic        prev_sign;
    logic        quiet = 1'b0;
    logic        sign_check = 1'b0;
    logic        want_sign;
    int unsigned nudges = 0;

    synctimer_top synctimer_top_i (
        .clk              (clk),
        .reset            (reset),
        .phase_min        (phase_min),
        .phase_max        (phase_max),
        .correct_time     (correct_time),
        .correct_valid    (correct_valid),
        .correct_override (correct_override),
        .current_time     (current_time),
        .adjust_valid     (adjust_valid),
        .adjust_sign      (adjust_sign)
    );

    always #50 clk = ~clk;

    // run limit from the worst case test lengths
    initial begin
        wait (cycles > MAX_CYCLES);
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
        return lo + (next_rand() >> 8) % (hi - lo + 1);
    endfunction

    task automatic check_time(input timer_t got, input timer_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // one clock: check the timer step and nudge flags, then advance the master
    task automatic step_cycle();
        logic   load;
        timer_t load_value;
        timer_t expected;
        load = correct_valid && correct_override;
        load_value = correct_time;
        @(negedge clk);
        cycles++;
        if (load) begin
            expected = load_value;
        end else if (prev_adj) begin
            expected = prev_sign ? prev_time + TIMER_STEP - 1 : prev_time + TIMER_STEP + 1;
        end else begin
            expected = prev_time + TIMER_STEP;
        end
        check_time(current_time, expected, "timer step");
        if (quiet) check_flag(adjust_valid, 1'b0, "nudge while quiet");
        if (sign_check && adjust_valid) begin
            check_flag(adjust_sign, want_sign, "nudge sign");
            nudges++;
        end
        prev_time = current_time;
        prev_adj  = adjust_valid;
        prev_sign = adjust_sign;
        correct_valid    = 1'b0;
        correct_override = 1'b0;
        master = master + TIMER_STEP;
        if (drift_on) begin
            drift_cnt++;
            if (drift_cnt >= drift_period) begin
                drift_cnt = 0;
                master = drift_fast ? master + 1 : master - 1;
            end
        end
    endtask

    task automatic wait_cycles(input int unsigned n);
        repeat (n) step_cycle();
    endtask

    task automatic send_override(input timer_t value);
        correct_time     = value;
        correct_valid    = 1'b1;
        correct_override = 1'b1;
        step_cycle();
        master = value; // in phase with the loaded timer
    endtask

    // phase is checked against the time the DUT samples on the next edge
    task automatic send_sample(input logic check_phase);
        longint phase;
        phase = longint'(master - current_time);
        if (check_phase && (phase > PHASE_LIMIT || phase < -PHASE_LIMIT)) begin
            errors++;
            $display("Fail %0t: phase error %0d outside limit %0d", $time, phase, PHASE_LIMIT);
        end
        correct_time  = master;
        correct_valid = 1'b1;
        step_cycle();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) tests_failed++;
        $display("test %-12s %s (%0d errors)", name,
                 (errors == errors_before) ? "ok" : "failed", errors - errors_before);
    endtask

    task automatic run_drift(input logic fast);
        drift_fast   = fast;
        drift_period = rand_range(50, 500);
        drift_cnt    = 0;
        drift_on     = 1'b1;
        want_sign    = !fast; // slow master needs slow-down nudges
        sign_check   = 1'b0;
        nudges       = 0;
        send_override({next_rand(), next_rand()});
        for (int i = 0; i < 50; i++) begin
            if (i >= 25) sign_check = 1'b1;
            wait_cycles(rand_range(200, 600));
            send_sample(i >= 40);
        end
        sign_check = 1'b0;
        drift_on   = 1'b0;
        if (nudges == 0) begin
            errors++;
            $display("no nudges seen in the second half of the drift run at %0t", $time);
        end
    endtask

    initial begin
        int start;
        reset            = 1'b1;
        phase_min        = -PHASE_LIMIT;
        phase_max        = PHASE_LIMIT;
        correct_time     = '0;
        correct_valid    = 1'b0;
        correct_override = 1'b0;
        master           = '0;
        repeat (10) @(negedge clk);

        // free run after reset
        start = errors;
        check_time(current_time, '0, "timer in reset");
        check_flag(adjust_valid, 1'b0, "nudge in reset");
        reset     = 1'b0;
        prev_time = current_time;
        prev_adj  = adjust_valid;
        prev_sign = adjust_sign;
        quiet = 1'b1;
        wait_cycles(T1_CYCLES);
        finish_test("free_run", start);

        // override, then no nudges until a second sample
        start = errors;
        send_override({next_rand(), next_rand()});
        wait_cycles(rand_range(200, 600));
        send_sample(1'b0);
        wait_cycles(rand_range(200, 600));
        send_sample(1'b0);
        quiet = 1'b0;
        finish_test("override", start);

        // master exactly at nominal rate and in phase
        start = errors;
        quiet = 1'b1;
        send_override({next_rand(), next_rand()});
        for (int i = 0; i < 10; i++) begin
            wait_cycles(rand_range(200, 550));
            send_sample(1'b1);
        end
        quiet = 1'b0;
        finish_test("zero_error", start);

        start = errors;
        run_drift(1'b1);
        finish_test("drift_fast", start);

        start = errors;
        run_drift(1'b0);
        finish_test("drift_slow", start);

        $display("tests run %0d, failed %0d, errors %0d, cycles %0d",
                 tests_run, tests_failed, errors, cycles);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
design/synctimer_pkg.sv
design/synctimer_timer.sv
design/synctimer_error_calc.sv
design/synctimer_loop_filter.sv
design/synctimer_divider.sv
design/synctimer_adjust_gen.sv
design/synctimer_top.sv
verif/synctimer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the time-sync testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module synctimer_tb -o simv
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
